// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_mem_stage
FILELIST  := tb.f

BIN       := obj_dir/V$(TOP)
SRCS      := $(wildcard hw/*.sv test/*.sv)
PASS_MSG  := Simulation finished: PASS

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# status comes from the search for the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== hw/data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_ram #(
    parameter int WORD_ADDR_W = pipeline_types::WORD_ADDR_W_DEFAULT
) (
    input wire logic clk,
    input wire logic reset_i,
    dmem_if.ram      bus_i
);

    localparam int DEPTH = 2 ** WORD_ADDR_W;

    // one array per byte lane, lane 0 is bits 7:0
    logic [7:0] ram0 [0:DEPTH-1];
    logic [7:0] ram1 [0:DEPTH-1];
    logic [7:0] ram2 [0:DEPTH-1];
    logic [7:0] ram3 [0:DEPTH-1];

    // masked write, not gated by ram_en
    always_ff @(posedge clk) begin
        if (bus_i.write_en) begin
            if (bus_i.select[3]) begin
                ram3[bus_i.word_addr] <= bus_i.wdata[31:24];
            end
            if (bus_i.select[2]) begin
                ram2[bus_i.word_addr] <= bus_i.wdata[23:16];
            end
            if (bus_i.select[1]) begin
                ram1[bus_i.word_addr] <= bus_i.wdata[15:8];
            end
            if (bus_i.select[0]) begin
                ram0[bus_i.word_addr] <= bus_i.wdata[7:0];
            end
        end
    end

    // registered read, zeros when idle or disabled
    always_ff @(posedge clk) begin
        if (bus_i.ram_en && bus_i.read_en) begin
            bus_i.rdata <= {ram3[bus_i.word_addr], ram2[bus_i.word_addr],
                            ram1[bus_i.word_addr], ram0[bus_i.word_addr]};
        end else begin
            bus_i.rdata <= '0;
        end
    end

    // one cycle after an enabled read
    always_ff @(posedge clk) begin
        if (reset_i) begin
            bus_i.data_valid <= 1'b0;
        end else begin
            bus_i.data_valid <= bus_i.ram_en & bus_i.read_en;
        end
    end

endmodule

`default_nettype wire

// ==== hw/dmem_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface dmem_if #(
    parameter int WORD_ADDR_W = pipeline_types::WORD_ADDR_W_DEFAULT
) ();

    // stage-wide enable, from the top level
    logic ram_en;

    // single-cycle strobes, never both high
    logic read_en;
    logic write_en;

    logic [WORD_ADDR_W-1:0]    word_addr;
    pipeline_types::byte_sel_t select;
    // store data already shifted into its lanes
    pipeline_types::bus32_t    wdata;

    // read side, valid one cycle after read_en
    pipeline_types::bus32_t    rdata;
    logic                      data_valid;

    modport requester (
        output read_en, write_en, word_addr, select, wdata
    );

    modport ram (
        input  ram_en, read_en, write_en, word_addr, select, wdata,
        output rdata, data_valid
    );

    modport consumer (
        input rdata, data_valid
    );

endinterface

`default_nettype wire

// ==== hw/load_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_align (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    dmem_if.consumer                        bus_i,
    input  wire pipeline_types::load_tag_t  load_tag_i,
    input  wire logic                       misaligned_i,
    output pipeline_types::bus32_t          load_data_o,
    output logic                            load_valid_o,
    output logic                            misaligned_o
);

    pipeline_types::load_tag_t tag_q;
    logic                      misaligned_q;
    logic [7:0]                byte_val;
    logic [15:0]               half_val;
    pipeline_types::bus32_t    extended;

    // tag lines up with data_valid one cycle later
    always_ff @(posedge clk) begin
        tag_q <= load_tag_i;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            misaligned_q <= 1'b0;
        end else begin
            misaligned_q <= misaligned_i;
        end
    end

    always_comb begin
        // pick the addressed byte
        case (tag_q.offset)
            2'd0:    byte_val = bus_i.rdata[7:0];
            2'd1:    byte_val = bus_i.rdata[15:8];
            2'd2:    byte_val = bus_i.rdata[23:16];
            default: byte_val = bus_i.rdata[31:24];
        endcase
        // halfword sits in the upper or lower half
        half_val = tag_q.offset[1] ? bus_i.rdata[31:16] : bus_i.rdata[15:0];
        case (tag_q.size)
            pipeline_types::SIZE_BYTE:
                extended = {{24{tag_q.sign_ext & byte_val[7]}}, byte_val};
            pipeline_types::SIZE_HALF:
                extended = {{16{tag_q.sign_ext & half_val[15]}}, half_val};
            default:
                extended = bus_i.rdata;
        endcase
    end

    // zero when nothing came back
    assign load_data_o  = bus_i.data_valid ? extended : '0;
    assign load_valid_o = bus_i.data_valid;
    assign misaligned_o = misaligned_q;

endmodule

`default_nettype wire

// ==== hw/mem_request.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_request (
    input  wire logic                     valid_i,
    input  wire pipeline_types::mem_op_t  op_i,
    input  wire pipeline_types::bus32_t   addr_i,
    input  wire pipeline_types::bus32_t   wdata_i,
    dmem_if.requester                     bus_o,
    output pipeline_types::load_tag_t     load_tag_o,
    output logic                          misaligned_o
);

    // word address width follows the interface
    localparam int ADDR_W = $bits(bus_o.word_addr);

    logic                      is_load;
    logic                      is_store;
    logic                      bad_align;
    pipeline_types::byte_sel_t sel;
    pipeline_types::bus32_t    lane_data;

    always_comb begin
        is_load            = 1'b0;
        is_store           = 1'b0;
        bad_align          = 1'b0;
        sel                = 4'b0000;
        lane_data          = wdata_i;
        load_tag_o.size    = pipeline_types::SIZE_WORD;
        load_tag_o.sign_ext = 1'b0;
        load_tag_o.offset  = addr_i[1:0];
        case (op_i)
            pipeline_types::MEM_LB, pipeline_types::MEM_LBU: begin
                is_load             = 1'b1;
                sel                 = 4'b0001 << addr_i[1:0];
                load_tag_o.size     = pipeline_types::SIZE_BYTE;
                load_tag_o.sign_ext = (op_i == pipeline_types::MEM_LB);
            end
            pipeline_types::MEM_LH, pipeline_types::MEM_LHU: begin
                is_load             = 1'b1;
                // halfword needs an even address
                bad_align           = addr_i[0];
                sel                 = addr_i[1] ? 4'b1100 : 4'b0011;
                load_tag_o.size     = pipeline_types::SIZE_HALF;
                load_tag_o.sign_ext = (op_i == pipeline_types::MEM_LH);
            end
            pipeline_types::MEM_LW: begin
                is_load   = 1'b1;
                bad_align = (addr_i[1:0] != 2'b00);
                sel       = 4'b1111;
            end
            pipeline_types::MEM_SB: begin
                is_store  = 1'b1;
                sel       = 4'b0001 << addr_i[1:0];
                // same byte in every lane, select picks one
                lane_data = {4{wdata_i[7:0]}};
            end
            pipeline_types::MEM_SH: begin
                is_store  = 1'b1;
                bad_align = addr_i[0];
                sel       = addr_i[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{wdata_i[15:0]}};
            end
            pipeline_types::MEM_SW: begin
                is_store  = 1'b1;
                bad_align = (addr_i[1:0] != 2'b00);
                sel       = 4'b1111;
            end
            default: begin
                sel = 4'b0000;
            end
        endcase
    end

    // strobes only for valid, aligned requests
    assign bus_o.read_en   = valid_i & is_load & ~bad_align;
    assign bus_o.write_en  = valid_i & is_store & ~bad_align;
    assign bus_o.select    = sel;
    assign bus_o.wdata     = lane_data;
    // drop the byte offset
    assign bus_o.word_addr = addr_i[ADDR_W+1:2];

    assign misaligned_o = valid_i & bad_align;

endmodule

`default_nettype wire

// ==== hw/mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage #(
    parameter int WORD_ADDR_W = pipeline_types::WORD_ADDR_W_DEFAULT
) (
    input  wire logic                     clk,
    input  wire logic                     reset_i,
    input  wire logic                     enable_i,
    input  wire logic                     valid_i,
    input  wire pipeline_types::mem_op_t  op_i,
    input  wire pipeline_types::bus32_t   addr_i,
    input  wire pipeline_types::bus32_t   wdata_i,
    output pipeline_types::bus32_t        load_data_o,
    output logic                          load_valid_o,
    output logic                          misaligned_o
);

    // request side to load side, same cycle as read_en
    pipeline_types::load_tag_t load_tag;
    // combinational flag, registered in load_align
    logic                      req_misaligned;

    dmem_if #(.WORD_ADDR_W(WORD_ADDR_W)) dmem ();

    // stage enable straight onto the bus
    assign dmem.ram_en = enable_i;

    mem_request u_mem_request (
        .valid_i      (valid_i),
        .op_i         (op_i),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .bus_o        (dmem.requester),
        .load_tag_o   (load_tag),
        .misaligned_o (req_misaligned)
    );

    data_ram #(
        .WORD_ADDR_W (WORD_ADDR_W)
    ) u_data_ram (
        .clk     (clk),
        .reset_i (reset_i),
        .bus_i   (dmem.ram)
    );

    load_align u_load_align (
        .clk          (clk),
        .reset_i      (reset_i),
        .bus_i        (dmem.consumer),
        .load_tag_i   (load_tag),
        .misaligned_i (req_misaligned),
        .load_data_o  (load_data_o),
        .load_valid_o (load_valid_o),
        .misaligned_o (misaligned_o)
    );

endmodule

`default_nettype wire

// ==== hw/pipeline_types.sv ====
`default_nettype none

package pipeline_types;

    // plain 32-bit data / address word
    typedef logic [31:0] bus32_t;

    // one bit per byte lane, bit 0 is the low byte
    typedef logic [3:0] byte_sel_t;

    // memory operations seen by the stage
    typedef enum logic [2:0] {
        MEM_LB  = 3'd0,
        MEM_LBU = 3'd1,
        MEM_LH  = 3'd2,
        MEM_LHU = 3'd3,
        MEM_LW  = 3'd4,
        MEM_SB  = 3'd5,
        MEM_SH  = 3'd6,
        MEM_SW  = 3'd7
    } mem_op_t;

    // access size carried with a read
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } load_size_t;

    // travels alongside read_en, used one cycle later
    typedef struct packed {
        load_size_t  size;
        logic        sign_ext;
        logic [1:0]  offset;
    } load_tag_t;

    // 1024 words by default
    localparam int WORD_ADDR_W_DEFAULT = 10;

endpackage

`default_nettype wire

// ==== tb.f ====
hw/pipeline_types.sv
hw/dmem_if.sv
hw/mem_request.sv
hw/data_ram.sv
hw/load_align.sv
hw/mem_stage.sv
test/mem_stage_assertions.sv
test/tb_mem_stage.sv

// ==== test/mem_stage_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage_assertions (
    input wire logic clk,
    input wire logic reset_i,
    input wire logic ram_en_i,
    input wire logic read_en_i,
    input wire logic write_en_i,
    input wire logic data_valid_i,
    input wire logic load_valid_i,
    input wire logic misaligned_i
);

    // one request per cycle, never a read and a write
    a_rw_exclusive: assert property (
        @(posedge clk) disable iff (reset_i) !(read_en_i && write_en_i)
    ) else $error("read_en and write_en high in the same cycle");

    // enabled read gives data one cycle later
    a_valid_follows_read: assert property (
        @(posedge clk) disable iff (reset_i) (read_en_i && ram_en_i) |=> data_valid_i
    ) else $error("data_valid missing one cycle after an enabled read");

    // and nothing else does
    a_no_spurious_valid: assert property (
        @(posedge clk) disable iff (reset_i) !(read_en_i && ram_en_i) |=> !data_valid_i
    ) else $error("data_valid without an enabled read the cycle before");

    // a misaligned request never returns data
    a_mis_without_valid: assert property (
        @(posedge clk) disable iff (reset_i) !(misaligned_i && load_valid_i)
    ) else $error("misaligned_o and load_valid_o high together");

endmodule

`default_nettype wire

// ==== test/tb_mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_stage;

    localparam int WORD_ADDR_W = 10;
    // byte address width of the reference memory
    localparam int BYTE_W = WORD_ADDR_W + 2;
    localparam int PERIOD = 8;
    localparam int RESET_CYCLES = 5;

    typedef struct packed {
        logic                    en;
        logic                    valid;
        pipeline_types::mem_op_t op;
        pipeline_types::bus32_t  addr;
        pipeline_types::bus32_t  data;
    } row_t;

    logic                    clk = 1'b0;
    logic                    reset_i;
    logic                    enable_i;
    logic                    valid_i;
    pipeline_types::mem_op_t op_i;
    pipeline_types::bus32_t  addr_i;
    pipeline_types::bus32_t  wdata_i;
    pipeline_types::bus32_t  load_data_o;
    logic                    load_valid_o;
    logic                    misaligned_o;

    row_t                    rows[$];
    // little-endian byte image of the data RAM
    logic [7:0]              ref_mem [0:(1 << BYTE_W)-1];
    logic                    table_ready = 1'b0;
    int                      errors = 0;
    int                      checks = 0;
    // expectation for the request of the previous cycle
    logic                    exp_valid;
    logic                    exp_mis;
    pipeline_types::bus32_t  exp_data;

    always #(PERIOD / 2) clk = ~clk;

    mem_stage #(.WORD_ADDR_W(WORD_ADDR_W)) i_dut (
        .clk          (clk),
        .reset_i      (reset_i),
        .enable_i     (enable_i),
        .valid_i      (valid_i),
        .op_i         (op_i),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .load_data_o  (load_data_o),
        .load_valid_o (load_valid_o),
        .misaligned_o (misaligned_o)
    );

    bind mem_stage mem_stage_assertions u_assertions (
        .clk          (clk),
        .reset_i      (reset_i),
        .ram_en_i     (dmem.ram_en),
        .read_en_i    (dmem.read_en),
        .write_en_i   (dmem.write_en),
        .data_valid_i (dmem.data_valid),
        .load_valid_i (load_valid_o),
        .misaligned_i (misaligned_o)
    );

    task automatic add_row(input logic en, input logic valid, input pipeline_types::mem_op_t op,
                           input pipeline_types::bus32_t addr, input pipeline_types::bus32_t data);
        rows.push_back('{en, valid, op, addr, data});
    endtask

    function automatic logic is_load(input pipeline_types::mem_op_t op);
        return (op == pipeline_types::MEM_LB) || (op == pipeline_types::MEM_LBU) ||
               (op == pipeline_types::MEM_LH) || (op == pipeline_types::MEM_LHU) ||
               (op == pipeline_types::MEM_LW);
    endfunction

    // halves need an even address, words a multiple of four
    function automatic logic misaligned_addr(input pipeline_types::mem_op_t op,
                                             input pipeline_types::bus32_t addr);
        case (op)
            pipeline_types::MEM_LH, pipeline_types::MEM_LHU, pipeline_types::MEM_SH:
                return addr[0];
            pipeline_types::MEM_LW, pipeline_types::MEM_SW:
                return addr[1:0] != 2'b00;
            default:
                return 1'b0;
        endcase
    endfunction

    function automatic pipeline_types::bus32_t ref_load(input pipeline_types::mem_op_t op,
                                                        input pipeline_types::bus32_t addr);
        logic [BYTE_W-1:0] a;
        logic [7:0]        b;
        logic [15:0]       h;
        a = addr[BYTE_W-1:0];
        b = ref_mem[a];
        h = {ref_mem[a + 2'd1], ref_mem[a]};
        case (op)
            pipeline_types::MEM_LB:  return {{24{b[7]}}, b};
            pipeline_types::MEM_LBU: return {24'h0, b};
            pipeline_types::MEM_LH:  return {{16{h[15]}}, h};
            pipeline_types::MEM_LHU: return {16'h0, h};
            default:                 return {ref_mem[a + 2'd3], ref_mem[a + 2'd2], h};
        endcase
    endfunction

    task automatic model_store(input pipeline_types::mem_op_t op,
                               input pipeline_types::bus32_t addr,
                               input pipeline_types::bus32_t data);
        logic [BYTE_W-1:0] a;
        a = addr[BYTE_W-1:0];
        ref_mem[a] = data[7:0];
        if (op != pipeline_types::MEM_SB) begin
            ref_mem[a + 2'd1] = data[15:8];
        end
        if (op == pipeline_types::MEM_SW) begin
            ref_mem[a + 2'd2] = data[23:16];
            ref_mem[a + 2'd3] = data[31:24];
        end
    endtask

    task automatic check_outputs();
        checks++;
        assert (load_valid_o === exp_valid) else begin
            errors++;
            $display("ERR %0t: load_valid_o is %b, expected %b", $time, load_valid_o, exp_valid);
        end
        assert (load_data_o === exp_data) else begin
            errors++;
            $display("ERR %0t: load_data_o is %h, expected %h", $time, load_data_o, exp_data);
        end
        assert (misaligned_o === exp_mis) else begin
            errors++;
            $display("ERR %0t: misaligned_o is %b, expected %b", $time, misaligned_o, exp_mis);
        end
    endtask

    initial begin
        row_t r;
        void'($urandom(32'hb55));
        reset_i   = 1'b1;
        enable_i  = 1'b0;
        valid_i   = 1'b0;
        op_i      = pipeline_types::MEM_LW;
        addr_i    = '0;
        wdata_i   = '0;
        // outputs idle right after reset
        exp_valid = 1'b0;
        exp_mis   = 1'b0;
        exp_data  = '0;

        // word, half and byte merged into one word
        add_row(1'b1, 1'b1, pipeline_types::MEM_SW, 32'h100, $urandom());
        add_row(1'b1, 1'b1, pipeline_types::MEM_SH, 32'h102, $urandom());
        add_row(1'b1, 1'b1, pipeline_types::MEM_SB, 32'h101, $urandom());
        add_row(1'b1, 1'b1, pipeline_types::MEM_LW, 32'h100, 32'h0);
        // one random word and one with mixed sign bits
        add_row(1'b1, 1'b1, pipeline_types::MEM_SW, 32'h200, $urandom());
        add_row(1'b1, 1'b1, pipeline_types::MEM_SW, 32'h204, 32'h807f_01ff);
        for (int k = 0; k < 8; k++) begin
            add_row(1'b1, 1'b1, pipeline_types::MEM_LB, 32'h200 + k, 32'h0);
            add_row(1'b1, 1'b1, pipeline_types::MEM_LBU, 32'h200 + k, 32'h0);
        end
        for (int k = 0; k < 8; k += 2) begin
            add_row(1'b1, 1'b1, pipeline_types::MEM_LH, 32'h200 + k, 32'h0);
            add_row(1'b1, 1'b1, pipeline_types::MEM_LHU, 32'h200 + k, 32'h0);
        end
        // misaligned requests, stores must not land
        add_row(1'b1, 1'b1, pipeline_types::MEM_LH, 32'h201, 32'h0);
        add_row(1'b1, 1'b1, pipeline_types::MEM_LHU, 32'h203, 32'h0);
        add_row(1'b1, 1'b1, pipeline_types::MEM_LW, 32'h202, 32'h0);
        add_row(1'b1, 1'b1, pipeline_types::MEM_SH, 32'h103, $urandom());
        add_row(1'b1, 1'b1, pipeline_types::MEM_SW, 32'h101, $urandom());
        add_row(1'b1, 1'b1, pipeline_types::MEM_LW, 32'h100, 32'h0);
        // load right behind a store to the same word
        add_row(1'b1, 1'b1, pipeline_types::MEM_SW, 32'h300, $urandom());
        add_row(1'b1, 1'b1, pipeline_types::MEM_LW, 32'h300, 32'h0);
        // back-to-back loads
        add_row(1'b1, 1'b1, pipeline_types::MEM_LW, 32'h100, 32'h0);
        add_row(1'b1, 1'b1, pipeline_types::MEM_LW, 32'h204, 32'h0);
        add_row(1'b1, 1'b1, pipeline_types::MEM_LW, 32'h300, 32'h0);
        // store with valid low is ignored
        add_row(1'b1, 1'b0, pipeline_types::MEM_SW, 32'h100, $urandom());
        add_row(1'b1, 1'b1, pipeline_types::MEM_LW, 32'h100, 32'h0);
        // disabled stage: loads give nothing, stores still write
        add_row(1'b0, 1'b1, pipeline_types::MEM_LW, 32'h100, 32'h0);
        add_row(1'b0, 1'b1, pipeline_types::MEM_SW, 32'h400, $urandom());
        add_row(1'b0, 1'b1, pipeline_types::MEM_LB, 32'h401, 32'h0);
        add_row(1'b1, 1'b1, pipeline_types::MEM_LW, 32'h400, 32'h0);
        table_ready = 1'b1;

        repeat (RESET_CYCLES) @(negedge clk);
        reset_i = 1'b0;

        for (int i = 0; i <= rows.size(); i++) begin
            check_outputs();
            if (i < rows.size()) begin
                r        = rows[i];
                enable_i = r.en;
                valid_i  = r.valid;
                op_i     = r.op;
                addr_i   = r.addr;
                wdata_i  = r.data;
                exp_mis   = r.valid && misaligned_addr(r.op, r.addr);
                exp_valid = r.valid && r.en && is_load(r.op) && !exp_mis;
                exp_data  = exp_valid ? ref_load(r.op, r.addr) : '0;
                // model write lands with the same edge as the RAM
                if (r.valid && !is_load(r.op) && !exp_mis) begin
                    model_store(r.op, r.addr, r.data);
                end
            end else begin
                valid_i = 1'b0;
            end
            @(negedge clk);
        end

        $display("errors: %0d in %0d checked cycles", errors, checks);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // table length plus reset plus some slack
    initial begin
        wait (table_ready);
        #((rows.size() + RESET_CYCLES + 20) * PERIOD);
        $display("timeout: the stimulus table did not finish in time");
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
